//--- verilog/dmem_consts.svh
`ifndef DMEM_CONSTS_SVH
`define DMEM_CONSTS_SVH

// Register and memory word width in bits
`define XLEN_BITS 64

// Data memory depth in words
`define DMEM_WORDS 256

// Result queue entries, also the LSU credit limit
`define RQ_DEPTH 2

// Bytes per memory word
`define XLEN_BYTES (`XLEN_BITS / 8)

// Address bits that select a byte inside a word
`define BYTE_OFF_BITS 3

`endif

//--- verilog/lsu_pkg.sv
`include "dmem_consts.svh"

package lsu_pkg;

    // Register file value, also used for pc and load result
    typedef logic [`XLEN_BITS-1:0] xword_t;

    // Signed immediate offset of a load or store
    typedef logic [11:0] imm12_t;

    // Destination register index
    typedef logic [4:0] reg_idx_t;

    // Access width, in the funct3 order of the ISA
    typedef enum logic [1:0] {
        MW_BYTE   = 2'd0,
        MW_HALF   = 2'd1,
        MW_WORD   = 2'd2,
        MW_DOUBLE = 2'd3
    } mem_width_e;

endpackage

//--- verilog/mem_pkg.sv
`include "dmem_consts.svh"

package mem_pkg;

    typedef logic [`XLEN_BITS-1:0] mem_addr_t;
    typedef logic [`XLEN_BITS-1:0] mem_data_t;

    // One enable bit per byte lane of a word
    typedef logic [`XLEN_BYTES-1:0] byte_mask_t;

    // Peer that owns a memory grant
    typedef enum logic {
        SRC_LSU   = 1'b0,
        SRC_FETCH = 1'b1
    } req_src_e;

endpackage

//--- verilog/load_store_unit.sv
`timescale 1ns/100ps
`include "dmem_consts.svh"

module load_store_unit (
    input  logic                           clk,
    input  logic                           rst,
    // Issue side
    input  lsu_pkg::xword_t                op_pc,
    input  lsu_pkg::reg_idx_t              op_dst,
    input  logic                           op_load,
    input  lsu_pkg::xword_t                op_base,
    input  lsu_pkg::imm12_t                op_offset,
    input  lsu_pkg::xword_t                op_source,
    input  logic                           op_unsigned,
    input  lsu_pkg::mem_width_e            op_width,
    input  logic                           op_valid,
    output logic                           op_ready,
    // Memory request and response
    output mem_pkg::mem_addr_t             lsu_req_addr,
    output mem_pkg::mem_data_t             lsu_req_wdata,
    output mem_pkg::byte_mask_t            lsu_req_mask,
    output logic                           lsu_req_wen,
    output logic                           lsu_req_valid,
    input  logic                           lsu_req_ready,
    input  mem_pkg::mem_data_t             lsu_resp_rdata,
    input  logic                           lsu_resp_valid,
    // Result queue write side
    output lsu_pkg::xword_t                wq_result,
    output lsu_pkg::xword_t                wq_pc,
    output lsu_pkg::reg_idx_t              wq_dst,
    output logic                           wq_wen,
    output logic                           wq_valid,
    input  logic [$clog2(`RQ_DEPTH+1)-1:0] wq_count,
    // Exceptions
    output logic                           misaligned_load,
    output logic                           misaligned_store
);

    import lsu_pkg::*;
    import mem_pkg::*;

    localparam int CNT_BITS = $clog2(`RQ_DEPTH + 1);

    mem_addr_t                  agu_addr;
    logic                       misaligned;
    logic                       op_fire;
    byte_mask_t                 base_mask;
    mem_data_t                  rep_data;
    logic [CNT_BITS-1:0]        inflight_q;
    logic [CNT_BITS:0]          credit_used;
    logic                       req_fire;

    // Metadata riding with the request register
    xword_t                     req_pc;
    reg_idx_t                   req_dst;
    logic                       req_load;
    logic [`BYTE_OFF_BITS-1:0]  req_off;
    mem_width_e                 req_width;
    logic                       req_unsigned;

    // Metadata of the request granted last, waiting for its response
    xword_t                     rsp_pc;
    reg_idx_t                   rsp_dst;
    logic                       rsp_load;
    logic [`BYTE_OFF_BITS-1:0]  rsp_off;
    mem_width_e                 rsp_width;
    logic                       rsp_unsigned;
    mem_data_t                  lane;
    xword_t                     load_val;

    // Effective address with sign-extended offset
    assign agu_addr = op_base + {{(`XLEN_BITS-12){op_offset[11]}}, op_offset};

    always_comb begin
        case (op_width)
            MW_BYTE: begin
                misaligned = 1'b0;
                base_mask  = 8'h01;
                rep_data   = {8{op_source[7:0]}};
            end
            MW_HALF: begin
                misaligned = agu_addr[0];
                base_mask  = 8'h03;
                rep_data   = {4{op_source[15:0]}};
            end
            MW_WORD: begin
                misaligned = |agu_addr[1:0];
                base_mask  = 8'h0f;
                rep_data   = {2{op_source[31:0]}};
            end
            default: begin
                misaligned = |agu_addr[2:0];
                base_mask  = 8'hff;
                rep_data   = op_source;
            end
        endcase
    end

    // Ops in flight plus queued results must leave room for every response
    assign credit_used = inflight_q + wq_count;
    assign op_ready    = (credit_used < `RQ_DEPTH) && (!lsu_req_valid || lsu_req_ready);
    assign op_fire     = op_valid && op_ready;
    assign req_fire    = lsu_req_valid && lsu_req_ready;

    assign misaligned_load  = op_fire && misaligned && op_load;
    assign misaligned_store = op_fire && misaligned && !op_load;

    always_ff @(posedge clk) begin
        if (rst) begin
            lsu_req_valid <= 1'b0;
        end else if (op_fire) begin
            lsu_req_valid <= !misaligned;
        end else if (lsu_req_ready) begin
            lsu_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op_fire) begin
            lsu_req_addr  <= agu_addr;
            lsu_req_wdata <= rep_data;
            lsu_req_mask  <= base_mask << agu_addr[`BYTE_OFF_BITS-1:0];
            lsu_req_wen   <= !op_load;
            req_pc        <= op_pc;
            req_dst       <= op_dst;
            req_load      <= op_load;
            req_off       <= agu_addr[`BYTE_OFF_BITS-1:0];
            req_width     <= op_width;
            req_unsigned  <= op_unsigned;
        end
    end

    // Memory answers in order, one response per grant
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_pc       <= req_pc;
            rsp_dst      <= req_dst;
            rsp_load     <= req_load;
            rsp_off      <= req_off;
            rsp_width    <= req_width;
            rsp_unsigned <= req_unsigned;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight_q <= '0;
        end else begin
            case ({op_fire && !misaligned, lsu_resp_valid})
                2'b10:   inflight_q <= inflight_q + 1'b1;
                2'b01:   inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase
        end
    end

    // Move the addressed lane down to bit 0
    assign lane = lsu_resp_rdata >> {rsp_off, 3'b000};

    always_comb begin
        case (rsp_width)
            MW_BYTE:
                load_val = rsp_unsigned ? {56'b0, lane[7:0]} : {{56{lane[7]}}, lane[7:0]};
            MW_HALF:
                load_val = rsp_unsigned ? {48'b0, lane[15:0]} : {{48{lane[15]}}, lane[15:0]};
            MW_WORD:
                load_val = rsp_unsigned ? {32'b0, lane[31:0]} : {{32{lane[31]}}, lane[31:0]};
            default:
                load_val = lane;
        endcase
    end

    // Stores leave a zero result
    assign wq_result = rsp_load ? load_val : '0;
    assign wq_pc     = rsp_pc;
    assign wq_dst    = rsp_dst;
    assign wq_wen    = rsp_load;
    assign wq_valid  = lsu_resp_valid;

endmodule

//--- verilog/result_queue.sv
`timescale 1ns/100ps
`include "dmem_consts.svh"

module result_queue (
    input  logic                           clk,
    input  logic                           rst,
    input  lsu_pkg::xword_t                in_result,
    input  lsu_pkg::xword_t                in_pc,
    input  lsu_pkg::reg_idx_t              in_dst,
    input  logic                           in_wen,
    input  logic                           in_valid,
    output logic                           in_ready,
    output lsu_pkg::xword_t                out_result,
    output lsu_pkg::xword_t                out_pc,
    output lsu_pkg::reg_idx_t              out_dst,
    output logic                           out_wen,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic [$clog2(`RQ_DEPTH+1)-1:0] count
);

    import lsu_pkg::*;

    localparam int PTR_BITS = $clog2(`RQ_DEPTH);

    xword_t               result_mem [`RQ_DEPTH];
    xword_t               pc_mem     [`RQ_DEPTH];
    reg_idx_t             dst_mem    [`RQ_DEPTH];
    logic                 wen_mem    [`RQ_DEPTH];
    logic [PTR_BITS-1:0]  wr_ptr;
    logic [PTR_BITS-1:0]  rd_ptr;
    logic                 push;
    logic                 pop;

    assign in_ready  = (count != `RQ_DEPTH);
    assign out_valid = (count != 0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    // Head entry drives the outputs directly
    assign out_result = result_mem[rd_ptr];
    assign out_pc     = pc_mem[rd_ptr];
    assign out_dst    = dst_mem[rd_ptr];
    assign out_wen    = wen_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            result_mem[wr_ptr] <= in_result;
            pc_mem[wr_ptr]     <= in_pc;
            dst_mem[wr_ptr]    <= in_dst;
            wen_mem[wr_ptr]    <= in_wen;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                clk,
    input  logic                rst,
    // LSU port
    input  mem_pkg::mem_addr_t  lsu_req_addr,
    input  mem_pkg::mem_data_t  lsu_req_wdata,
    input  mem_pkg::byte_mask_t lsu_req_mask,
    input  logic                lsu_req_wen,
    input  logic                lsu_req_valid,
    output logic                lsu_req_ready,
    output mem_pkg::mem_data_t  lsu_resp_rdata,
    output logic                lsu_resp_valid,
    // Fetch port, reads only
    input  mem_pkg::mem_addr_t  fetch_req_addr,
    input  logic                fetch_req_valid,
    output logic                fetch_req_ready,
    output mem_pkg::mem_data_t  fetch_resp_rdata,
    output logic                fetch_resp_valid,
    // RAM port
    output logic                ram_en,
    output logic                ram_wen,
    output mem_pkg::mem_addr_t  ram_addr,
    output mem_pkg::mem_data_t  ram_wdata,
    output mem_pkg::byte_mask_t ram_mask,
    input  mem_pkg::mem_data_t  ram_rdata,
    input  logic                ram_rvalid
);

    import mem_pkg::*;

    // Winner of the latest grant, which also steers the next response
    req_src_e last_src;
    logic     grant_lsu;
    logic     grant_fetch;

    // On a tie the peer that lost last time goes first
    assign grant_lsu   = lsu_req_valid && (!fetch_req_valid || last_src == SRC_FETCH);
    assign grant_fetch = fetch_req_valid && !grant_lsu;

    assign lsu_req_ready   = grant_lsu;
    assign fetch_req_ready = grant_fetch;

    assign ram_en    = grant_lsu || grant_fetch;
    assign ram_wen   = grant_lsu && lsu_req_wen;
    assign ram_addr  = grant_lsu ? lsu_req_addr : fetch_req_addr;
    assign ram_wdata = lsu_req_wdata;
    assign ram_mask  = grant_lsu ? lsu_req_mask : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_src <= SRC_FETCH;
        end else if (ram_en) begin
            last_src <= grant_lsu ? SRC_LSU : SRC_FETCH;
        end
    end

    assign lsu_resp_valid   = ram_rvalid && (last_src == SRC_LSU);
    assign fetch_resp_valid = ram_rvalid && (last_src == SRC_FETCH);
    assign lsu_resp_rdata   = ram_rdata;
    assign fetch_resp_rdata = ram_rdata;

endmodule

//--- verilog/data_ram.sv
`timescale 1ns/100ps
`include "dmem_consts.svh"

module data_ram (
    input  logic                clk,
    input  logic                ram_en,
    input  logic                ram_wen,
    input  mem_pkg::mem_addr_t  ram_addr,
    input  mem_pkg::mem_data_t  ram_wdata,
    input  mem_pkg::byte_mask_t ram_mask,
    output mem_pkg::mem_data_t  ram_rdata,
    output logic                ram_rvalid
);

    import mem_pkg::*;

    localparam int IDX_BITS = $clog2(`DMEM_WORDS);

    mem_data_t           mem [`DMEM_WORDS];
    logic [IDX_BITS-1:0] idx;

    // Word index sits right above the byte offset
    assign idx = ram_addr[`BYTE_OFF_BITS +: IDX_BITS];

    always_ff @(posedge clk) begin
        if (ram_en && ram_wen) begin
            for (int b = 0; b < `XLEN_BYTES; b++) begin
                if (ram_mask[b]) begin
                    mem[idx][b*8 +: 8] <= ram_wdata[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, data is valid the cycle after the grant
    always_ff @(posedge clk) begin
        ram_rvalid <= ram_en;
        if (ram_en) begin
            ram_rdata <= mem[idx];
        end
    end

endmodule

//--- verilog/lsu_subsys.sv
`timescale 1ns/100ps
`include "dmem_consts.svh"

module lsu_subsys (
    input  logic                clk,
    input  logic                rst,
    // Issue
    input  lsu_pkg::xword_t     op_pc,
    input  lsu_pkg::reg_idx_t   op_dst,
    input  logic                op_load,
    input  lsu_pkg::xword_t     op_base,
    input  lsu_pkg::imm12_t     op_offset,
    input  lsu_pkg::xword_t     op_source,
    input  logic                op_unsigned,
    input  lsu_pkg::mem_width_e op_width,
    input  logic                op_valid,
    output logic                op_ready,
    // Writeback
    output lsu_pkg::xword_t     wb_result,
    output lsu_pkg::xword_t     wb_pc,
    output lsu_pkg::reg_idx_t   wb_dst,
    output logic                wb_wen,
    output logic                wb_valid,
    input  logic                wb_ready,
    output logic                misaligned_load,
    output logic                misaligned_store,
    // Instruction fetch
    input  mem_pkg::mem_addr_t  fetch_req_addr,
    input  logic                fetch_req_valid,
    output logic                fetch_req_ready,
    output mem_pkg::mem_data_t  fetch_resp_rdata,
    output logic                fetch_resp_valid
);

    import lsu_pkg::*;
    import mem_pkg::*;

    mem_addr_t                      lsu_req_addr;
    mem_data_t                      lsu_req_wdata;
    byte_mask_t                     lsu_req_mask;
    logic                           lsu_req_wen;
    logic                           lsu_req_valid;
    logic                           lsu_req_ready;
    mem_data_t                      lsu_resp_rdata;
    logic                           lsu_resp_valid;
    xword_t                         wq_result;
    xword_t                         wq_pc;
    reg_idx_t                       wq_dst;
    logic                           wq_wen;
    logic                           wq_valid;
    logic [$clog2(`RQ_DEPTH+1)-1:0] wq_count;
    logic                           ram_en;
    logic                           ram_wen;
    mem_addr_t                      ram_addr;
    mem_data_t                      ram_wdata;
    byte_mask_t                     ram_mask;
    mem_data_t                      ram_rdata;
    logic                           ram_rvalid;

    load_store_unit load_store_unit_i (.*);

    // Credit in the LSU guarantees space, so in_ready is not needed
    result_queue result_queue_i (
        .clk        (clk),
        .rst        (rst),
        .in_result  (wq_result),
        .in_pc      (wq_pc),
        .in_dst     (wq_dst),
        .in_wen     (wq_wen),
        .in_valid   (wq_valid),
        .in_ready   (),
        .out_result (wb_result),
        .out_pc     (wb_pc),
        .out_dst    (wb_dst),
        .out_wen    (wb_wen),
        .out_valid  (wb_valid),
        .out_ready  (wb_ready),
        .count      (wq_count)
    );

    mem_arbiter mem_arbiter_i (.*);

    data_ram data_ram_i (.*);

endmodule

//--- verif/lsu_subsys_chk.sv
`timescale 1ns/100ps
`include "dmem_consts.svh"

module lsu_subsys_chk (
    input logic                           clk,
    input logic                           rst,
    input logic                           req_valid,
    input logic                           req_ready,
    input mem_pkg::mem_addr_t             req_addr,
    input logic                           ram_en,
    input logic                           ram_rvalid,
    input logic                           op_valid,
    input logic                           op_ready,
    input logic                           op_mis,
    input logic                           resp_valid,
    input logic [$clog2(`RQ_DEPTH+1)-1:0] queued
);

    // Number of failed assertions in this instance
    int unsigned fail_cnt = 0;

    // Accepted aligned ops still waiting for their memory response
    int unsigned outstanding;

    always_ff @(posedge clk) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + 32'(op_valid && op_ready && !op_mis)
                         - 32'(resp_valid);
        end
    end

    // A pending request holds until the arbiter takes it
    req_hold_a: assert property (@(posedge clk) disable iff (rst)
        req_valid && !req_ready |=> req_valid && $stable(req_addr))
    else begin
        $error("LSU request dropped or changed before grant");
        fail_cnt++;
    end

    rvalid_follows_a: assert property (@(posedge clk) disable iff (rst)
        ram_rvalid == $past(ram_en))
    else begin
        $error("ram_rvalid does not follow ram_en by one cycle");
        fail_cnt++;
    end

    // In-flight ops and queued results together may not exceed the queue
    credit_stall_a: assert property (@(posedge clk) disable iff (rst)
        outstanding + queued >= `RQ_DEPTH |-> !op_ready)
    else begin
        $error("op_ready high with no credit left");
        fail_cnt++;
    end

endmodule

// The LSU has no RAM port and the arbiter sees no issue traffic
bind load_store_unit lsu_subsys_chk lsu_chk_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (lsu_req_valid),
    .req_ready  (lsu_req_ready),
    .req_addr   (lsu_req_addr),
    .ram_en     (1'b0),
    .ram_rvalid (1'b0),
    .op_valid   (op_valid),
    .op_ready   (op_ready),
    .op_mis     (misaligned_load || misaligned_store),
    .resp_valid (lsu_resp_valid),
    .queued     (wq_count)
);

bind mem_arbiter lsu_subsys_chk arb_chk_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (lsu_req_valid),
    .req_ready  (lsu_req_ready),
    .req_addr   (lsu_req_addr),
    .ram_en     (ram_en),
    .ram_rvalid (ram_rvalid),
    .op_valid   (1'b0),
    .op_ready   (1'b0),
    .op_mis     (1'b0),
    .resp_valid (1'b0),
    .queued     ('0)
);

//--- verif/lsu_subsys_tb.sv
`timescale 1ns/100ps
`include "dmem_consts.svh"

module lsu_subsys_tb;

    import lsu_pkg::*;
    import mem_pkg::*;

    localparam int N_FILL      = 32;
    localparam int N_STORE     = 24;
    localparam int N_LOAD      = 48;
    localparam int N_MIS       = 8;
    localparam int N_BP        = 40;
    localparam int N_FETCH     = 40;
    localparam int N_OPS       = N_FILL + N_STORE + N_LOAD + 2 * N_MIS + N_BP;
    localparam int CYCLE_LIMIT = 40 * N_OPS + 500;

    typedef struct packed {
        xword_t   result;
        xword_t   pc;
        reg_idx_t dst;
        logic     wen;
    } wb_rec_t;

    logic       clk = 1'b0;
    logic       rst;
    xword_t     op_pc;
    reg_idx_t   op_dst;
    logic       op_load;
    xword_t     op_base;
    imm12_t     op_offset;
    xword_t     op_source;
    logic       op_unsigned;
    mem_width_e op_width;
    logic       op_valid;
    logic       op_ready;
    xword_t     wb_result;
    xword_t     wb_pc;
    reg_idx_t   wb_dst;
    logic       wb_wen;
    logic       wb_valid;
    logic       wb_ready;
    logic       misaligned_load;
    logic       misaligned_store;
    mem_addr_t  fetch_req_addr;
    logic       fetch_req_valid;
    logic       fetch_req_ready;
    mem_data_t  fetch_resp_rdata;
    logic       fetch_resp_valid;

    integer      seed = 55435;
    mem_data_t   shadow [`DMEM_WORDS];
    wb_rec_t     exp_q [$];
    wb_rec_t     exp_rec;
    xword_t      pc_next = 64'h1000;
    int          bp_mode = 0;
    int unsigned mismatch_errs = 0;
    int unsigned other_errs = 0;
    int unsigned assert_errs;
    int unsigned cycles = 0;

    lsu_subsys lsu_subsys_i (.*);

    always #10 clk = ~clk;

    task automatic check_xword(string name, xword_t got, xword_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            mismatch_errs++;
        end
    endtask

    task automatic check_reg_idx(string name, reg_idx_t got, reg_idx_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            mismatch_errs++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            mismatch_errs++;
        end
    endtask

    task automatic check_mem_data(string name, mem_data_t got, mem_data_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            mismatch_errs++;
        end
    endtask

    // Expected load value: shift the lane down, then zero or sign extend
    function automatic xword_t load_ref(mem_addr_t addr, mem_width_e w, logic uns);
        xword_t lane;
        xword_t keep;
        int     nbits;
        lane  = shadow[(addr / 8) % `DMEM_WORDS] >> (8 * addr[2:0]);
        nbits = 8 << w;
        if (nbits == `XLEN_BITS) begin
            return lane;
        end
        keep = (xword_t'(1) << nbits) - 1;
        if (!uns && lane[nbits-1]) begin
            return lane | ~keep;
        end
        return lane & keep;
    endfunction

    task automatic store_ref(mem_addr_t addr, mem_width_e w, xword_t src);
        int idx;
        idx = (addr / 8) % `DMEM_WORDS;
        for (int b = 0; b < (1 << w); b++) begin
            shadow[idx][8 * (addr[2:0] + b) +: 8] = src[8 * b +: 8];
        end
    endtask

    // Entered on a falling edge, returns on the falling edge after the transfer
    task automatic issue_op(logic load, mem_width_e w, logic uns, mem_addr_t addr, xword_t src);
        imm12_t  imm;
        logic    mis;
        wb_rec_t rec;
        imm         = imm12_t'($random(seed));
        op_load     = load;
        op_width    = w;
        op_unsigned = uns;
        op_offset   = imm;
        op_base     = addr - {{(`XLEN_BITS-12){imm[11]}}, imm};
        op_source   = src;
        op_pc       = pc_next;
        op_dst      = reg_idx_t'($random(seed));
        op_valid    = 1'b1;
        mis         = (addr & ((1 << w) - 1)) != 0;
        #5;
        while (!op_ready) begin
            @(negedge clk);
            #5;
        end
        check_bit("misaligned_load", misaligned_load, mis && load);
        check_bit("misaligned_store", misaligned_store, mis && !load);
        if (!mis) begin
            rec.result = load ? load_ref(addr, w, uns) : '0;
            rec.pc     = pc_next;
            rec.dst    = op_dst;
            rec.wen    = load;
            exp_q.push_back(rec);
            if (!load) begin
                store_ref(addr, w, src);
            end
        end
        pc_next = pc_next + 4;
        @(negedge clk);
        op_valid = 1'b0;
    endtask

    task automatic random_aligned_op(logic load, mem_width_e w, logic uns, int lo, int n);
        int unsigned word;
        int unsigned off;
        word = lo + $unsigned($random(seed)) % n;
        off  = $unsigned($random(seed)) & 7 & ~((1 << w) - 1);
        issue_op(load, w, uns, mem_addr_t'(word * 8 + off), {$random(seed), $random(seed)});
    endtask

    task automatic drain_results();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // LSU stores stay in words 0 to 15 from here on
    task automatic lsu_traffic();
        int unsigned word;
        int unsigned off;
        mem_width_e  w;
        for (int i = 0; i < N_STORE; i++) begin
            random_aligned_op(1'b0, mem_width_e'(i % 4), 1'b0, 0, 16);
        end
        for (int i = 0; i < N_LOAD; i++) begin
            random_aligned_op(1'b1, mem_width_e'(i % 4), (i / 4) % 2, 0, N_FILL);
        end
        for (int i = 0; i < N_MIS; i++) begin
            w    = mem_width_e'(1 + i % 3);
            word = $unsigned($random(seed)) % 16;
            off  = $unsigned($random(seed)) & 7;
            if (off % (1 << w) == 0) begin
                off = off + 1;
            end
            issue_op(i % 2 == 0, w, 1'b0, mem_addr_t'(word * 8 + off),
                     {$random(seed), $random(seed)});
            issue_op(1'b1, MW_DOUBLE, 1'b0, mem_addr_t'(word * 8), '0);
        end
        // Hold writeback off so two ops use up all credit
        drain_results();
        bp_mode = 1;
        random_aligned_op(1'b1, MW_WORD, 1'b0, 0, 16);
        random_aligned_op(1'b0, MW_HALF, 1'b0, 0, 16);
        #5;
        check_bit("op_ready", op_ready, 1'b0);
        repeat (8) @(negedge clk);
        #5;
        check_bit("op_ready", op_ready, 1'b0);
        @(negedge clk);
        bp_mode = 2;
        for (int i = 2; i < N_BP; i++) begin
            random_aligned_op($random(seed) & 1, mem_width_e'($random(seed) & 3),
                              $random(seed) & 1, 0, 16);
        end
        drain_results();
        bp_mode = 0;
    endtask

    // Reads of words filled once and never stored to again
    task automatic run_fetch();
        int unsigned word;
        int unsigned waits;
        for (int i = 0; i < N_FETCH; i++) begin
            word            = 16 + $unsigned($random(seed)) % 16;
            fetch_req_addr  = mem_addr_t'(word * 8);
            fetch_req_valid = 1'b1;
            waits           = 0;
            #5;
            while (!fetch_req_ready) begin
                check_bit("fetch_resp_valid", fetch_resp_valid, 1'b0);
                waits++;
                @(negedge clk);
                #5;
            end
            // Round robin lets the LSU win at most once in a row
            if (waits > 1) begin
                $display("fetch request waited %0d cycles for a grant at %0t", waits, $time);
                other_errs++;
            end
            @(negedge clk);
            fetch_req_valid = 1'b0;
            #5;
            check_bit("fetch_resp_valid", fetch_resp_valid, 1'b1);
            check_mem_data("fetch_resp_rdata", fetch_resp_rdata, shadow[word]);
            @(negedge clk);
            repeat ($unsigned($random(seed)) % 4) @(negedge clk);
        end
    endtask

    initial begin
        wb_ready = 1'b1;
        forever begin
            @(negedge clk);
            case (bp_mode)
                0:       wb_ready = 1'b1;
                1:       wb_ready = 1'b0;
                default: wb_ready = ($random(seed) & 3) != 0;
            endcase
        end
    end

    // Compare every writeback handshake against the oldest expected record
    always begin
        @(negedge clk);
        #5;
        if (wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
                $display("writeback record arrived with no operation outstanding");
                other_errs++;
            end else begin
                exp_rec = exp_q.pop_front();
                check_xword("wb_pc", wb_pc, exp_rec.pc);
                check_reg_idx("wb_dst", wb_dst, exp_rec.dst);
                check_bit("wb_wen", wb_wen, exp_rec.wen);
                if (exp_rec.wen) begin
                    check_xword("wb_result", wb_result, exp_rec.result);
                end
            end
        end
    end

    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d records pending", cycles, exp_q.size());
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst             = 1'b1;
        op_pc           = '0;
        op_dst          = '0;
        op_load         = 1'b0;
        op_base         = '0;
        op_offset       = '0;
        op_source       = '0;
        op_unsigned     = 1'b0;
        op_width        = MW_BYTE;
        op_valid        = 1'b0;
        fetch_req_addr  = '0;
        fetch_req_valid = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        #5;
        check_bit("op_ready", op_ready, 1'b1);
        check_bit("wb_valid", wb_valid, 1'b0);
        check_bit("fetch_resp_valid", fetch_resp_valid, 1'b0);
        check_bit("misaligned_load", misaligned_load, 1'b0);
        check_bit("misaligned_store", misaligned_store, 1'b0);
        check_bit("lsu_req_valid", lsu_subsys_i.lsu_req_valid, 1'b0);
        check_bit("ram_en", lsu_subsys_i.ram_en, 1'b0);
        @(negedge clk);
        // Whole words first so every later lane is known
        for (int i = 0; i < N_FILL; i++) begin
            issue_op(1'b0, MW_DOUBLE, 1'b0, mem_addr_t'(i * 8), {$random(seed), $random(seed)});
        end
        drain_results();
        fork
            run_fetch();
            lsu_traffic();
        join
        drain_results();
        assert_errs = lsu_subsys_i.load_store_unit_i.lsu_chk_i.fail_cnt
                    + lsu_subsys_i.mem_arbiter_i.arb_chk_i.fail_cnt;
        $display("errors: %0d mismatch, %0d other, %0d assertion",
                 mismatch_errs, other_errs, assert_errs);
        if (mismatch_errs + other_errs + assert_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+verilog
verilog/lsu_pkg.sv
verilog/mem_pkg.sv
verilog/load_store_unit.sv
verilog/result_queue.sv
verilog/mem_arbiter.sv
verilog/data_ram.sv
verilog/lsu_subsys.sv
verif/lsu_subsys_chk.sv
verif/lsu_subsys_tb.sv

//--- Makefile
VERILATOR = verilator
TOP       = lsu_subsys_tb
FILELIST  = vlog.f
OBJDIR    = obj_dir
VFLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(OBJDIR)
RUNFLAGS  = +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf $(OBJDIR)
